/* hw/vrc6_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, fixed bank fields and encodings shared by the VRC6 mapper blocks.
// Modules reach them through vrc6_pkg:: scoped names.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package vrc6_pkg;

	// Bus and bank widths
	localparam int CPU_AW     = 16;         // CPU address bus
	localparam int PPU_AW     = 14;         // PPU address bus
	localparam int OUT_AW     = 22;         // Translated PRG and CHR addresses
	localparam int PRG_BANK_W = 6;          // 8 KB PRG bank number
	localparam int CHR_BANK_W = 8;          // 1 KB CHR bank number
	localparam int CHR_BANKS  = 8;          // Eight 1 KB windows in pattern space

	// Fixed fields of the translated addresses
	localparam logic [PRG_BANK_W-1:0] PRG_LAST_BANK = 6'h3F;         // Bank at 0xE000
	localparam logic [8:0]            PRG_RAM_BASE  = 9'b111100000;  // Work RAM region
	localparam logic [2:0]            CHR_REGION    = 3'b100;        // CHR space select

	// IRQ prescaler, 341 PPU dots over three CPU-cycle groups
	localparam int SCALER_W = 7;
	localparam logic [SCALER_W-1:0] SCALER_LONG  = 7'd113;
	localparam logic [SCALER_W-1:0] SCALER_SHORT = 7'd112;

	// Register selected by a CPU write, after the A0/A1 swap
	typedef enum logic [3:0] {
		REG_NONE,                            // Not a mapper register
		REG_PRG8,                            // 0x800x, 16 KB bank at 0x8000
		REG_PRGC,                            // 0xC00x, 8 KB bank at 0xC000
		REG_MIRROR,                          // 0xB003
		REG_CHR0,                            // 0xD000
		REG_CHR1,
		REG_CHR2,
		REG_CHR3,
		REG_CHR4,                            // 0xE000
		REG_CHR5,
		REG_CHR6,
		REG_CHR7,
		REG_IRQ_LATCH,                       // 0xF000
		REG_IRQ_CTRL,                        // 0xF001
		REG_IRQ_ACK                          // 0xF002
	} vrc6_reg_e;

	// Nametable mirroring, the value written to bits 3..2 of 0xB003
	typedef enum logic [1:0] {
		MIR_VERT,                            // A10 picks the page
		MIR_HORZ,                            // A11 picks the page
		MIR_ONE_LO,                          // Single screen, lower page
		MIR_ONE_HI                           // Single screen, upper page
	} vrc6_mirror_e;

endpackage

/* hw/vrc6_reg_if.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded CPU register writes, passed from the decoder to the IRQ timer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface vrc6_reg_if;

	// A write lands in the cycle where ce and wr are both high
	logic                ce;             // One pulse per CPU cycle
	logic                wr;             // CPU write
	vrc6_pkg::vrc6_reg_e sel;            // Addressed register
	logic [7:0]          data;           // CPU write data

	modport decode (
		output ce,
		output wr,
		output sel,
		output data
	);

	modport irq (
		input ce,
		input wr,
		input sel,
		input data
	);

endinterface

/* hw/vrc6_reg_decode.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU write decoder; holds bank and mirroring registers, forwards IRQ writes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module vrc6_reg_decode (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 ce,
	input  logic                                 prg_write,
	input  logic [vrc6_pkg::CPU_AW-1:0]          prg_ain,
	input  logic [7:0]                           prg_din,
	input  logic                                 variant_26,
	vrc6_reg_if.decode                           bus,
	output logic [vrc6_pkg::PRG_BANK_W-2:0]      prg_bank8,
	output logic [vrc6_pkg::PRG_BANK_W-1:0]      prg_bankc,
	output logic [vrc6_pkg::CHR_BANKS-1:0][vrc6_pkg::CHR_BANK_W-1:0] chr_bank,
	output vrc6_pkg::vrc6_mirror_e               mirror
);

	logic [vrc6_pkg::CPU_AW-1:0] ain;
	logic [2:0]                  chr_idx;
	vrc6_pkg::vrc6_reg_e         sel;

	// Mapper 26 boards wire A0 and A1 crossed
	assign ain = variant_26 ? {prg_ain[15:2], prg_ain[0], prg_ain[1]} : prg_ain;

	// 0xD00x selects banks 0..3, 0xE00x banks 4..7
	assign chr_idx = {ain[13], ain[1:0]};

	always_comb begin
		sel = vrc6_pkg::REG_NONE;
		case (ain[15:12])
			4'h8: sel = vrc6_pkg::REG_PRG8;
			4'hB: begin
				if (ain[1:0] == 2'b11)
					sel = vrc6_pkg::REG_MIRROR;
			end
			4'hC: sel = vrc6_pkg::REG_PRGC;
			4'hD, 4'hE: begin
				sel = vrc6_pkg::vrc6_reg_e'(4'(vrc6_pkg::REG_CHR0) + {1'b0, chr_idx});
			end
			4'hF: begin
				case (ain[1:0])
					2'b00:   sel = vrc6_pkg::REG_IRQ_LATCH;
					2'b01:   sel = vrc6_pkg::REG_IRQ_CTRL;
					2'b10:   sel = vrc6_pkg::REG_IRQ_ACK;
					default: sel = vrc6_pkg::REG_NONE;   // 0xF003 unused
				endcase
			end
			default: sel = vrc6_pkg::REG_NONE;
		endcase
	end

	// Bank and mirroring registers
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			prg_bank8 <= '0;
			prg_bankc <= '0;
			chr_bank  <= '0;
			mirror    <= vrc6_pkg::MIR_VERT;
		end else if (ce && prg_write) begin
			case (sel)
				vrc6_pkg::REG_PRG8:   prg_bank8 <= prg_din[vrc6_pkg::PRG_BANK_W-2:0];
				vrc6_pkg::REG_PRGC:   prg_bankc <= prg_din[vrc6_pkg::PRG_BANK_W-1:0];
				vrc6_pkg::REG_MIRROR: mirror <= vrc6_pkg::vrc6_mirror_e'(prg_din[3:2]);
				default: begin
					if (sel inside {[vrc6_pkg::REG_CHR0:vrc6_pkg::REG_CHR7]})
						chr_bank[chr_idx] <= prg_din;
				end
			endcase
		end
	end

	// IRQ registers live in the timer, every write is forwarded
	assign bus.ce   = ce;
	assign bus.wr   = prg_write;
	assign bus.sel  = sel;
	assign bus.data = prg_din;

	// Work RAM and lower space never reach a bank register
	a_no_bank_below_8000: assert property (@(posedge clk) disable iff (reset)
		ce && prg_write && !prg_ain[15] |=> $stable(prg_bank8) && $stable(prg_bankc)
			&& $stable(chr_bank) && $stable(mirror))
		else $error("bank or mirroring register changed by a write below 0x8000");

endmodule

/* hw/vrc6_addr_map.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational PRG/CHR translation, nametable routing and access enables
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module vrc6_addr_map (
	input  logic [vrc6_pkg::CPU_AW-1:0]          prg_ain,
	input  logic [vrc6_pkg::PPU_AW-1:0]          chr_ain,
	input  logic                                 prg_write,
	input  logic                                 chr_ram,
	input  logic [vrc6_pkg::PRG_BANK_W-2:0]      prg_bank8,
	input  logic [vrc6_pkg::PRG_BANK_W-1:0]      prg_bankc,
	input  logic [vrc6_pkg::CHR_BANKS-1:0][vrc6_pkg::CHR_BANK_W-1:0] chr_bank,
	input  vrc6_pkg::vrc6_mirror_e               mirror,
	output logic [vrc6_pkg::OUT_AW-1:0]          prg_aout,
	output logic                                 prg_allow,
	output logic [vrc6_pkg::OUT_AW-1:0]          chr_aout,
	output logic                                 chr_allow,
	output logic                                 vram_a10,
	output logic                                 vram_ce
);

	logic                            prg_is_ram;
	logic [vrc6_pkg::PRG_BANK_W-1:0] prg_bank;
	logic [vrc6_pkg::CHR_BANK_W-1:0] chr_sel_bank;
	logic                            a10_sel;

	assign prg_is_ram = (prg_ain[15:13] == 3'b011);   // 0x6000-0x7FFF

	always_comb begin
		case (prg_ain[15:13])
			3'b100, 3'b101: prg_bank = {prg_bank8, prg_ain[13]};   // 16 KB window
			3'b110:         prg_bank = prg_bankc;
			3'b111:         prg_bank = vrc6_pkg::PRG_LAST_BANK;
			default:        prg_bank = '0;
		endcase
	end

	assign prg_aout = prg_is_ram ? {vrc6_pkg::PRG_RAM_BASE, prg_ain[12:0]}
	                             : {3'b000, prg_bank, prg_ain[12:0]};

	// Reads of ROM space, any access to work RAM
	assign prg_allow = (prg_ain[15] && !prg_write) || prg_is_ram;

	assign chr_sel_bank = chr_bank[chr_ain[12:10]];

	// Nametables take A10 from the mirroring mode instead of the bank
	always_comb begin
		if (!chr_ain[13]) begin
			a10_sel = chr_sel_bank[0];
		end else begin
			unique case (mirror)
				vrc6_pkg::MIR_VERT:   a10_sel = chr_ain[10];
				vrc6_pkg::MIR_HORZ:   a10_sel = chr_ain[11];
				vrc6_pkg::MIR_ONE_LO: a10_sel = 1'b0;
				vrc6_pkg::MIR_ONE_HI: a10_sel = 1'b1;
			endcase
		end
	end

	assign chr_aout = {vrc6_pkg::CHR_REGION, 1'b0,
	                   chr_sel_bank[vrc6_pkg::CHR_BANK_W-1:1], a10_sel, chr_ain[9:0]};

	assign vram_ce   = chr_ain[13];                 // Nametable space goes to VRAM
	assign vram_a10  = a10_sel;
	assign chr_allow = chr_ram && !chr_ain[13];     // Pattern writes only on CHR RAM boards

endmodule

/* hw/vrc6_irq.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VRC IRQ timer, scanline or CPU-cycle mode, fed by decoded register writes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module vrc6_irq (
	input  logic       clk,
	input  logic       reset,
	vrc6_reg_if.irq    bus,
	output logic       irq
);

	logic [7:0]                    latch;
	logic [7:0]                    counter;
	logic [vrc6_pkg::SCALER_W-1:0] scaler;
	logic [1:0]                    phase;     // Position in the 113/113/112 pattern
	logic                          mode;      // M, count every CPU cycle
	logic                          ack_en;    // A, copied into E on acknowledge
	logic                          en;        // E
	logic                          pending;
	logic                          latch_wr;
	logic                          ctrl_wr;
	logic                          ack_wr;
	logic                          step;
	logic                          tick;
	logic                          en_nxt;
	logic                          pend_nxt;

	assign latch_wr = bus.ce && bus.wr && (bus.sel == vrc6_pkg::REG_IRQ_LATCH);
	assign ctrl_wr  = bus.ce && bus.wr && (bus.sel == vrc6_pkg::REG_IRQ_CTRL);
	assign ack_wr   = bus.ce && bus.wr && (bus.sel == vrc6_pkg::REG_IRQ_ACK);

	// Control write owns the cycle, no count on the same ce
	assign step = bus.ce && en && !ctrl_wr;
	assign tick = mode || (scaler == '0);

	always_ff @(posedge clk) begin
		if (latch_wr)
			latch <= bus.data;
	end

	// Prescaler and counter
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			scaler  <= vrc6_pkg::SCALER_LONG;
			phase   <= 2'd0;
			counter <= 8'd0;
		end else if (ctrl_wr && bus.data[1]) begin
			scaler  <= vrc6_pkg::SCALER_LONG;
			phase   <= 2'd0;
			counter <= latch;
		end else if (step) begin
			if (scaler != '0) begin
				scaler <= scaler - 1'b1;
			end else begin
				scaler <= phase[1] ? vrc6_pkg::SCALER_SHORT : vrc6_pkg::SCALER_LONG;
				phase  <= phase[1] ? 2'd0 : phase + 2'd1;
			end
			if (tick)
				counter <= (counter == 8'hFF) ? latch : counter + 8'd1;
		end
	end

	always_comb begin
		en_nxt   = en;
		pend_nxt = pending;
		if (ctrl_wr)
			en_nxt = bus.data[1];
		else if (ack_wr)
			en_nxt = ack_en;
		if (ctrl_wr || ack_wr)
			pend_nxt = 1'b0;                    // Either write acknowledges
		else if (step && tick && counter == 8'hFF)
			pend_nxt = 1'b1;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			mode    <= 1'b0;
			ack_en  <= 1'b0;
			en      <= 1'b0;
			pending <= 1'b0;
			irq     <= 1'b0;
		end else begin
			if (ctrl_wr) begin
				mode   <= bus.data[2];
				ack_en <= bus.data[0];
			end
			en      <= en_nxt;
			pending <= pend_nxt;
			irq     <= pend_nxt && en_nxt;
		end
	end

	// E must already be set in the cycle before irq goes high
	a_irq_needs_enable: assert property (@(posedge clk) disable iff (reset)
		$rose(irq) |-> $past(en))
		else $error("irq rose with the IRQ enable low");

endmodule

/* hw/vrc6_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VRC6 mapper top level (mappers 24 and 26), plain CPU and PPU bus ports
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module vrc6_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        ce,          // One pulse per CPU cycle
	input  logic [vrc6_pkg::CPU_AW-1:0] prg_ain,
	input  logic                        prg_write,
	input  logic [7:0]                  prg_din,
	input  logic [vrc6_pkg::PPU_AW-1:0] chr_ain,
	input  logic                        variant_26,  // Mapper 26 wiring
	input  logic                        chr_ram,
	output logic [vrc6_pkg::OUT_AW-1:0] prg_aout,
	output logic                        prg_allow,
	output logic [vrc6_pkg::OUT_AW-1:0] chr_aout,
	output logic                        chr_allow,
	output logic                        vram_a10,
	output logic                        vram_ce,
	output logic                        irq
);

	logic [vrc6_pkg::PRG_BANK_W-2:0]                           prg_bank8;
	logic [vrc6_pkg::PRG_BANK_W-1:0]                           prg_bankc;
	logic [vrc6_pkg::CHR_BANKS-1:0][vrc6_pkg::CHR_BANK_W-1:0] chr_bank;
	vrc6_pkg::vrc6_mirror_e                                    mirror;

	vrc6_reg_if reg_bus ();

	vrc6_reg_decode u_decode (
		.clk        (clk),
		.reset      (reset),
		.ce         (ce),
		.prg_write  (prg_write),
		.prg_ain    (prg_ain),
		.prg_din    (prg_din),
		.variant_26 (variant_26),
		.bus        (reg_bus.decode),
		.prg_bank8  (prg_bank8),
		.prg_bankc  (prg_bankc),
		.chr_bank   (chr_bank),
		.mirror     (mirror)
	);

	vrc6_addr_map u_map (
		.prg_ain   (prg_ain),
		.chr_ain   (chr_ain),
		.prg_write (prg_write),
		.chr_ram   (chr_ram),
		.prg_bank8 (prg_bank8),
		.prg_bankc (prg_bankc),
		.chr_bank  (chr_bank),
		.mirror    (mirror),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr_aout  (chr_aout),
		.chr_allow (chr_allow),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce)
	);

	vrc6_irq u_irq (
		.clk   (clk),
		.reset (reset),
		.bus   (reg_bus.irq),
		.irq   (irq)
	);

endmodule

/* verif/vrc6_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the VRC6 mapper top level; assertions compare the DUT
// with a register model kept from the writes the stimulus makes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module vrc6_tb;

	localparam int CLK_PERIOD     = 4;
	localparam int RESET_CYCLES   = 8;
	localparam int PRG_ROUNDS     = 8;
	localparam int PRG_READS      = 4;          // Per window and round
	localparam int CHR_READS      = 32;
	localparam int NT_READS       = 8;          // Per mirror mode
	localparam int IDLE_AFTER_ACK = 300;        // CPU cycles with irq expected low
	localparam int NEVER          = 32'h4000_0000;
	localparam int CPU_CYCLES     = PRG_ROUNDS * (4 + 4 * PRG_READS) + 2 * (8 + CHR_READS)
		+ 4 * (1 + NT_READS) + 2 * (6 + 2 * 64 + IDLE_AFTER_ACK);
	// Four clocks per CPU cycle, doubled for margin
	localparam int WATCHDOG_TIME  = (RESET_CYCLES + 8 * CPU_CYCLES) * CLK_PERIOD;

	localparam logic [5:0] LAST_BANK = 6'h3F;
	localparam logic [8:0] RAM_FIELD = 9'b111100000;
	localparam logic [2:0] CHR_FIELD = 3'b100;

	logic        clk;
	logic        reset;
	logic        ce;
	logic [15:0] prg_ain;
	logic        prg_write;
	logic [7:0]  prg_din;
	logic [13:0] chr_ain;
	logic        variant_26;
	logic        chr_ram;
	logic [21:0] prg_aout;
	logic        prg_allow;
	logic [21:0] chr_aout;
	logic        chr_allow;
	logic        vram_a10;
	logic        vram_ce;
	logic        irq;

	// Register model
	logic [4:0]  m_prg8;
	logic [5:0]  m_prgc;
	logic [7:0]  m_chr [8];
	logic [1:0]  m_mirror;

	logic        prg_chk;
	logic        chr_chk;
	logic        irq_watch;                   // Rise window checks active
	logic        restart;                     // Marks the IRQ control write
	logic        ack_now;                     // Marks the IRQ acknowledge write
	int          exp_rise;                    // ce count at which irq must rise
	int          ce_since = 0;                // ce pulses since the control write
	int          prg_errs = 0;
	int          chr_errs = 0;
	int          irq_errs = 0;
	logic [31:0] seed = 32'hd0da;

	logic [5:0]  exp_bank;
	logic [21:0] exp_prg_aout;
	logic        exp_prg_allow;
	logic [7:0]  exp_chr_bank;
	logic [21:0] exp_chr_aout;
	logic        exp_a10;

	vrc6_top u_dut (
		.clk        (clk),
		.reset      (reset),
		.ce         (ce),
		.prg_ain    (prg_ain),
		.prg_write  (prg_write),
		.prg_din    (prg_din),
		.chr_ain    (chr_ain),
		.variant_26 (variant_26),
		.chr_ram    (chr_ram),
		.prg_aout   (prg_aout),
		.prg_allow  (prg_allow),
		.chr_aout   (chr_aout),
		.chr_allow  (chr_allow),
		.vram_a10   (vram_a10),
		.vram_ce    (vram_ce),
		.irq        (irq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		if (ce)
			ce_since <= restart ? 0 : ce_since + 1;
	end

	// Expected translation from the model
	always_comb begin
		case (prg_ain[15:13])
			3'b100, 3'b101: exp_bank = {m_prg8, prg_ain[13]};   // 16 KB window
			3'b110:         exp_bank = m_prgc;
			default:        exp_bank = LAST_BANK;
		endcase
	end

	assign exp_prg_aout  = (prg_ain[15:13] == 3'b011) ? {RAM_FIELD, prg_ain[12:0]}
	                                                   : {3'b000, exp_bank, prg_ain[12:0]};
	assign exp_prg_allow = (prg_ain[15] && !prg_write) || (prg_ain[15:13] == 3'b011);
	assign exp_chr_bank  = m_chr[chr_ain[12:10]];
	assign exp_chr_aout  = {CHR_FIELD, 1'b0, exp_chr_bank, chr_ain[9:0]};

	always_comb begin
		case (m_mirror)
			2'd0:    exp_a10 = chr_ain[10];     // Vertical
			2'd1:    exp_a10 = chr_ain[11];     // Horizontal
			2'd2:    exp_a10 = 1'b0;
			default: exp_a10 = 1'b1;
		endcase
	end

	a_prg_addr: assert property (@(posedge clk) disable iff (reset)
		prg_chk |-> prg_aout == exp_prg_aout)
		else begin
			prg_errs++;
			$display("FAIL t=%0t: prg_aout %h for ain %h, expected %h", $time,
				$sampled(prg_aout), $sampled(prg_ain), $sampled(exp_prg_aout));
		end

	a_prg_allow: assert property (@(posedge clk) disable iff (reset)
		prg_chk |-> prg_allow == exp_prg_allow)
		else begin
			prg_errs++;
			$display("FAIL t=%0t: prg_allow %b for ain %h, expected %b", $time,
				$sampled(prg_allow), $sampled(prg_ain), $sampled(exp_prg_allow));
		end

	a_chr_addr: assert property (@(posedge clk) disable iff (reset)
		chr_chk && !chr_ain[13] |-> chr_aout == exp_chr_aout && chr_allow == chr_ram
			&& !vram_ce)
		else begin
			chr_errs++;
			$display("FAIL t=%0t: chr_aout %h allow %b vram_ce %b for ain %h, expected %h",
				$time, $sampled(chr_aout), $sampled(chr_allow), $sampled(vram_ce),
				$sampled(chr_ain), $sampled(exp_chr_aout));
		end

	a_nametable: assert property (@(posedge clk) disable iff (reset)
		chr_chk && chr_ain[13] |-> vram_ce && !chr_allow && vram_a10 == exp_a10)
		else begin
			chr_errs++;
			$display("FAIL t=%0t: vram_ce %b vram_a10 %b for ain %h, expected a10 %b", $time,
				$sampled(vram_ce), $sampled(vram_a10), $sampled(chr_ain), $sampled(exp_a10));
		end

	a_irq_early: assert property (@(posedge clk) disable iff (reset)
		irq_watch && ce_since + 1 < exp_rise |-> !irq)
		else begin
			irq_errs++;
			$display("FAIL t=%0t: irq high after %0d ce pulses, rise due at %0d", $time,
				$sampled(ce_since), $sampled(exp_rise));
		end

	a_irq_late: assert property (@(posedge clk) disable iff (reset)
		irq_watch && ce_since > exp_rise |-> irq)
		else begin
			irq_errs++;
			$display("FAIL t=%0t: irq low after %0d ce pulses, rise due at %0d", $time,
				$sampled(ce_since), $sampled(exp_rise));
		end

	a_ack_drop: assert property (@(posedge clk) disable iff (reset)
		ack_now && ce |=> !irq)
		else begin
			irq_errs++;
			$display("FAIL t=%0t: irq still high the cycle after acknowledge", $time);
		end

	a_reset_irq: assert property (@(posedge clk) $fell(reset) |-> !irq)
		else begin
			irq_errs++;
			$display("FAIL t=%0t: irq high right after reset", $time);
		end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Register address with the A0/A1 swap of mapper 26 boards
	function automatic logic [15:0] reg_addr(input logic [15:0] base, input logic [1:0] idx);
		return base | {14'd0, variant_26 ? {idx[0], idx[1]} : idx};
	endfunction

	// One CPU cycle of four clocks, ce on the first
	task automatic cpu_cycle(input logic [15:0] addr, input logic wr, input logic [7:0] data);
		@(negedge clk);
		prg_ain   = addr;
		prg_write = wr;
		prg_din   = data;
		ce        = 1'b1;
		@(negedge clk);
		ce        = 1'b0;
		prg_write = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic prg_access(input logic [15:0] addr, input logic wr);
		prg_chk = 1'b1;
		cpu_cycle(addr, wr, 8'h00);
		prg_chk = 1'b0;
	endtask

	task automatic chr_read(input logic [13:0] addr);
		chr_ain = addr;
		chr_chk = 1'b1;
		cpu_cycle(16'h8000, 1'b0, 8'h00);
		chr_chk = 1'b0;
	endtask

	task automatic idle_until(input int n);
		while (ce_since < n)
			cpu_cycle(16'h8000, 1'b0, 8'h00);
	endtask

	task automatic prg_test();
		for (int r = 0; r < PRG_ROUNDS; r++) begin
			seed = xorshift32(seed);
			cpu_cycle(16'h8000, 1'b1, seed[7:0]);
			m_prg8 = seed[4:0];
			seed = xorshift32(seed);
			cpu_cycle(16'hC000, 1'b1, seed[7:0]);
			m_prgc = seed[5:0];
			for (int i = 0; i < PRG_READS; i++) begin
				seed = xorshift32(seed);
				prg_access({2'b10, seed[13:0]}, 1'b0);
				prg_access({3'b110, seed[28:16]}, 1'b0);
				prg_access({3'b111, seed[12:0]}, 1'b0);
				prg_access({3'b011, seed[25:13]}, 1'b0);
			end
			prg_access({3'b011, seed[12:0]}, 1'b1);   // Work RAM write
			prg_access({4'h9, seed[27:16]}, 1'b1);    // ROM write, no register at 0x9xxx
		end
	endtask

	task automatic chr_test(input logic v26);
		variant_26 = v26;
		chr_ram    = !v26;
		for (int b = 0; b < 8; b++) begin
			seed = xorshift32(seed);
			cpu_cycle(reg_addr((b < 4) ? 16'hD000 : 16'hE000, 2'(b)), 1'b1, seed[7:0]);
			m_chr[b] = seed[7:0];
		end
		for (int i = 0; i < CHR_READS; i++) begin
			seed = xorshift32(seed);
			chr_read({1'b0, seed[12:0]});
		end
	endtask

	task automatic mirror_test();
		for (int m = 0; m < 4; m++) begin
			cpu_cycle(16'hB003, 1'b1, {4'h0, 2'(m), 2'b00});
			m_mirror = 2'(m);
			for (int i = 0; i < NT_READS; i++) begin
				seed = xorshift32(seed);
				chr_read({1'b1, seed[12:0]});
			end
		end
	endtask

	// Cycle mode run, then acknowledge with the A bit given
	task automatic irq_test(input logic [7:0] lat, input logic a_bit);
		irq_watch = 1'b0;
		cpu_cycle(16'hF000, 1'b1, lat);
		restart = 1'b1;
		cpu_cycle(16'hF001, 1'b1, {5'd0, 1'b1, 1'b1, a_bit});   // M, E, A
		restart = 1'b0;
		exp_rise  = 256 - int'(lat);
		irq_watch = 1'b1;
		idle_until(exp_rise + 2);
		irq_watch = 1'b0;
		ack_now = 1'b1;
		cpu_cycle(16'hF002, 1'b1, 8'h00);
		ack_now = 1'b0;
		exp_rise  = a_bit ? 2 * (256 - int'(lat)) : NEVER;
		irq_watch = 1'b1;
		idle_until(a_bit ? exp_rise + 2 : IDLE_AFTER_ACK);
		irq_watch = 1'b0;
	endtask

	initial begin
		reset      = 1'b1;
		ce         = 1'b0;
		prg_ain    = 16'h0000;
		prg_write  = 1'b0;
		prg_din    = 8'h00;
		chr_ain    = 14'h0000;
		variant_26 = 1'b0;
		chr_ram    = 1'b1;
		m_prg8     = '0;
		m_prgc     = '0;
		m_mirror   = 2'd0;
		for (int b = 0; b < 8; b++)
			m_chr[b] = 8'h00;
		prg_chk    = 1'b0;
		chr_chk    = 1'b0;
		irq_watch  = 1'b0;
		restart    = 1'b0;
		ack_now    = 1'b0;
		exp_rise   = NEVER;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		prg_test();
		chr_test(1'b0);
		chr_test(1'b1);
		mirror_test();
		variant_26 = 1'b0;
		seed = xorshift32(seed);
		irq_test(8'hC0 + 8'(seed % 32'd48), 1'b1);
		seed = xorshift32(seed);
		irq_test(8'hC0 + 8'(seed % 32'd48), 1'b0);
		repeat (4) @(negedge clk);

		$display("Error counts: prg %0d, chr %0d, irq %0d", prg_errs, chr_errs, irq_errs);
		if (prg_errs + chr_errs + irq_errs == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog expired: tests did not finish within %0d time units",
			WATCHDOG_TIME);
		$display("Regression failed");
		$finish;
	end

endmodule

/* all.f */
hw/vrc6_pkg.sv
hw/vrc6_reg_if.sv
hw/vrc6_reg_decode.sv
hw/vrc6_addr_map.sv
hw/vrc6_irq.sv
hw/vrc6_top.sv
verif/vrc6_tb.sv

/* run.sh */
#!/bin/sh
# Builds the VRC6 testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module vrc6_tb \
	-f all.f --Mdir "$OBJ" -o vrc6_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$OBJ/vrc6_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0
